// File: common/cpu_pkg.sv
// shared widths, opcodes, function codes and instruction formats, referenced by scoped name
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'hbfc0_0000;  // mips boot vector

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_e;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;  // word index inside the 256 MB region
    } j_fmt_t;

    // one instruction word seen through its three formats
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

// File: common/instr_if.sv
// carries one instruction and its pc downstream and a credit pulse back upstream between blocks
interface instr_if ();

    logic                     valid;   // item present this cycle
    logic [cpu_pkg::xlen-1:0] pc;
    cpu_pkg::instr_u          instr;
    logic                     credit;  // consumer freed one entry

    modport producer (
        output valid,
        output pc,
        output instr,
        input  credit
    );

    modport consumer (
        input  valid,
        input  pc,
        input  instr,
        output credit
    );

endinterface

// File: fetch/fetch_unit.sv
// instruction fetch, issues sram reads against credits from the fetch queue and tags each word
module fetch_unit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    instr_if.producer                out,
    input  logic                     redirect_i,
    input  logic [cpu_pkg::xlen-1:0] redirect_pc_i,
    output logic                     inst_sram_en_o,
    output logic [cpu_pkg::xlen-1:0] inst_sram_addr_o,
    input  logic [cpu_pkg::xlen-1:0] inst_sram_rdata_i
);

    localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

    logic [cpu_pkg::xlen-1:0] pc_q;
    logic [cpu_pkg::xlen-1:0] pend_pc_q;  // pc of the read in flight
    logic [cnt_w-1:0]         credits_q;
    logic                     pend_q;
    logic                     run_q;      // first cycle out of reset issues nothing
    logic                     issue;

    assign issue = run_q && (credits_q != '0) && !redirect_i;

    assign inst_sram_en_o   = issue;
    assign inst_sram_addr_o = pc_q;

    // returned word goes straight onto the link, dropped if a redirect lands now
    assign out.valid = pend_q && !redirect_i;
    assign out.pc    = pend_pc_q;
    assign out.instr = inst_sram_rdata_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q      <= cpu_pkg::reset_pc;
            credits_q <= cnt_w'(QUEUE_DEPTH);
            pend_q    <= 1'b0;
            run_q     <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            pend_q <= issue;  // never set in a redirect cycle
            if (redirect_i) begin
                pc_q      <= redirect_pc_i;
                credits_q <= cnt_w'(QUEUE_DEPTH);  // queue is emptied alongside
            end else begin
                if (issue) begin
                    pc_q <= pc_q + 32'd4;
                end
                credits_q <= credits_q - cnt_w'(issue) + cnt_w'(out.credit);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pend_pc_q <= pc_q;
        end
    end

endmodule

// File: fetch/fetch_queue.sv
// show-ahead instruction fifo between fetch and execute, returns a credit per entry taken
module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      arst_n_i,
    instr_if.consumer in,
    instr_if.producer out,
    input  logic      flush_i
);

    localparam int ptr_w = $clog2(QUEUE_DEPTH);
    localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

    logic [cpu_pkg::xlen-1:0] pc_mem [QUEUE_DEPTH];
    cpu_pkg::instr_u          instr_mem [QUEUE_DEPTH];

    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             push;
    logic             pop;

    // credits upstream guarantee there is room for every push
    assign push = in.valid && !flush_i;
    assign pop  = out.credit && (count_q != '0);

    assign in.credit = pop;  // entry freed this cycle

    assign out.valid = (count_q != '0);
    assign out.pc    = pc_mem[rd_ptr_q];
    assign out.instr = instr_mem[rd_ptr_q];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_q]    <= in.pc;
            instr_mem[wr_ptr_q] <= in.instr;
        end
    end

endmodule

// File: execute/exec_unit.sv
// decode, alu, branch resolution, load/store and writeback for the head of the fetch queue
module exec_unit (
    input  logic                           clk,
    input  logic                           arst_n_i,
    instr_if.consumer                      in,
    output logic                           redirect_o,
    output logic [cpu_pkg::xlen-1:0]       redirect_pc_o,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_raddr_a_o,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_raddr_b_o,
    input  logic [cpu_pkg::xlen-1:0]       rf_rdata_a_i,
    input  logic [cpu_pkg::xlen-1:0]       rf_rdata_b_i,
    output logic                           rf_we_o,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_waddr_o,
    output logic [cpu_pkg::xlen-1:0]       rf_wdata_o,
    output logic                           data_sram_en_o,
    output logic [3:0]                     data_sram_wen_o,
    output logic [cpu_pkg::xlen-1:0]       data_sram_addr_o,
    output logic [cpu_pkg::xlen-1:0]       data_sram_wdata_o,
    input  logic [cpu_pkg::xlen-1:0]       data_sram_rdata_i,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_pc_o,
    output logic [3:0]                     debug_wb_rf_wen_o,
    output logic [cpu_pkg::reg_addr_w-1:0] debug_wb_rf_wnum_o,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_rf_wdata_o
);

    cpu_pkg::alu_op_e               alu_op;
    logic                           use_imm;
    logic                           imm_zext;
    logic                           wr_en;     // alu result goes to the register file
    logic                           wr_rd;     // destination is rd, else rt
    logic                           is_lw;
    logic                           is_sw;
    logic                           is_beq;
    logic                           is_bne;
    logic                           is_j;
    logic [cpu_pkg::xlen-1:0]       imm_ext;
    logic [cpu_pkg::xlen-1:0]       op_b;
    logic [cpu_pkg::xlen-1:0]       alu_res;
    logic [cpu_pkg::xlen-1:0]       pc_plus4;
    logic [cpu_pkg::xlen-1:0]       br_target;
    logic [cpu_pkg::xlen-1:0]       j_target;
    logic                           taken;
    logic                           take;
    logic                           load_pend_q;  // idle / waiting for load data
    logic [cpu_pkg::xlen-1:0]       load_pc_q;
    logic [cpu_pkg::reg_addr_w-1:0] load_dst_q;
    logic [cpu_pkg::reg_addr_w-1:0] wb_num;
    logic [cpu_pkg::xlen-1:0]       wb_pc;

    // nothing is taken while a load is outstanding
    assign take      = in.valid && !load_pend_q;
    assign in.credit = take;

    assign rf_raddr_a_o = in.instr.r.rs;
    assign rf_raddr_b_o = in.instr.r.rt;

    always_comb begin
        alu_op   = cpu_pkg::alu_add;
        use_imm  = 1'b0;
        imm_zext = 1'b0;
        wr_en    = 1'b0;
        wr_rd    = 1'b0;
        is_lw    = 1'b0;
        is_sw    = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        is_j     = 1'b0;
        case (in.instr.r.opcode)
            cpu_pkg::op_special: begin
                wr_en = 1'b1;
                wr_rd = 1'b1;
                case (in.instr.r.funct)
                    cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                    default:          wr_en  = 1'b0;  // unsupported funct retires silently
                endcase
            end
            cpu_pkg::op_addiu: begin
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            cpu_pkg::op_ori: begin
                alu_op   = cpu_pkg::alu_or;
                use_imm  = 1'b1;
                imm_zext = 1'b1;
                wr_en    = 1'b1;
            end
            cpu_pkg::op_lui: begin
                alu_op = cpu_pkg::alu_lui;
                wr_en  = 1'b1;
            end
            cpu_pkg::op_lw: begin
                use_imm = 1'b1;  // address = rs + offset
                is_lw   = 1'b1;
            end
            cpu_pkg::op_sw: begin
                use_imm = 1'b1;
                is_sw   = 1'b1;
            end
            cpu_pkg::op_beq: is_beq = 1'b1;
            cpu_pkg::op_bne: is_bne = 1'b1;
            cpu_pkg::op_j:   is_j   = 1'b1;
            default: ;
        endcase
    end

    assign imm_ext = imm_zext ? {16'b0, in.instr.i.imm}
                              : {{16{in.instr.i.imm[15]}}, in.instr.i.imm};
    assign op_b    = use_imm ? imm_ext : rf_rdata_b_i;

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add: alu_res = rf_rdata_a_i + op_b;
            cpu_pkg::alu_sub: alu_res = rf_rdata_a_i - op_b;
            cpu_pkg::alu_and: alu_res = rf_rdata_a_i & op_b;
            cpu_pkg::alu_or:  alu_res = rf_rdata_a_i | op_b;
            cpu_pkg::alu_xor: alu_res = rf_rdata_a_i ^ op_b;
            cpu_pkg::alu_slt: alu_res = {{(cpu_pkg::xlen - 1){1'b0}},
                                         $signed(rf_rdata_a_i) < $signed(op_b)};
            cpu_pkg::alu_lui: alu_res = {in.instr.i.imm, 16'b0};
            default:          alu_res = '0;
        endcase
    end

    // no delay slot, fall-through is simply the next queued word
    assign pc_plus4  = in.pc + 32'd4;
    assign br_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], in.instr.j.target, 2'b00};

    assign taken = (is_beq && (rf_rdata_a_i == rf_rdata_b_i))
                || (is_bne && (rf_rdata_a_i != rf_rdata_b_i))
                || is_j;

    assign redirect_o    = take && taken;
    assign redirect_pc_o = is_j ? j_target : br_target;

    assign data_sram_en_o    = take && (is_lw || is_sw);
    assign data_sram_wen_o   = {4{take && is_sw}};
    assign data_sram_addr_o  = alu_res;
    assign data_sram_wdata_o = rf_rdata_b_i;

    // load data has priority, take is low while it returns
    assign wb_num = load_pend_q ? load_dst_q
                  : (wr_rd ? in.instr.r.rd : in.instr.r.rt);
    assign wb_pc  = load_pend_q ? load_pc_q : in.pc;

    assign rf_we_o    = (load_pend_q || (take && wr_en)) && (wb_num != '0);
    assign rf_waddr_o = wb_num;
    assign rf_wdata_o = load_pend_q ? data_sram_rdata_i : alu_res;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            load_pend_q       <= 1'b0;
            debug_wb_rf_wen_o <= 4'b0000;
        end else begin
            load_pend_q       <= take && is_lw;  // back to idle once data is in
            debug_wb_rf_wen_o <= {4{rf_we_o}};
        end
    end

    always_ff @(posedge clk) begin
        if (take && is_lw) begin
            load_pc_q  <= in.pc;
            load_dst_q <= in.instr.i.rt;
        end
        if (rf_we_o) begin
            debug_wb_pc_o       <= wb_pc;
            debug_wb_rf_wnum_o  <= rf_waddr_o;
            debug_wb_rf_wdata_o <= rf_wdata_o;
        end
    end

endmodule

// File: logic/reg_file.sv
// general purpose register file, two combinational reads and one clocked write, r0 reads zero
module reg_file (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr_a_i,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr_b_i,
    output logic [cpu_pkg::xlen-1:0]       rdata_a_o,
    output logic [cpu_pkg::xlen-1:0]       rdata_b_o,
    input  logic                           we_i,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [cpu_pkg::xlen-1:0]       wdata_i
);

    localparam int num_regs = 2 ** cpu_pkg::reg_addr_w;

    logic [cpu_pkg::xlen-1:0] regs_q [num_regs];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // r0 never written
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// File: logic/mini_cpu_top.sv
// core top level, ties fetch, queue, execute and register file to the sram and debug ports
module mini_cpu_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           arst_n_i,
    output logic                           inst_sram_en_o,
    output logic [cpu_pkg::xlen-1:0]       inst_sram_addr_o,
    input  logic [cpu_pkg::xlen-1:0]       inst_sram_rdata_i,
    output logic                           data_sram_en_o,
    output logic [3:0]                     data_sram_wen_o,
    output logic [cpu_pkg::xlen-1:0]       data_sram_addr_o,
    output logic [cpu_pkg::xlen-1:0]       data_sram_wdata_o,
    input  logic [cpu_pkg::xlen-1:0]       data_sram_rdata_i,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_pc_o,
    output logic [3:0]                     debug_wb_rf_wen_o,
    output logic [cpu_pkg::reg_addr_w-1:0] debug_wb_rf_wnum_o,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_rf_wdata_o
);

    logic                           redirect;
    logic [cpu_pkg::xlen-1:0]       redirect_pc;
    logic [cpu_pkg::reg_addr_w-1:0] rf_raddr_a;
    logic [cpu_pkg::reg_addr_w-1:0] rf_raddr_b;
    logic [cpu_pkg::xlen-1:0]       rf_rdata_a;
    logic [cpu_pkg::xlen-1:0]       rf_rdata_b;
    logic                           rf_we;
    logic [cpu_pkg::reg_addr_w-1:0] rf_waddr;
    logic [cpu_pkg::xlen-1:0]       rf_wdata;

    instr_if f2q ();  // fetch to queue
    instr_if q2x ();  // queue to execute

    fetch_unit #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_fetch (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .out              (f2q.producer),
        .redirect_i       (redirect),
        .redirect_pc_i    (redirect_pc),
        .inst_sram_en_o   (inst_sram_en_o),
        .inst_sram_addr_o (inst_sram_addr_o),
        .inst_sram_rdata_i(inst_sram_rdata_i)
    );

    fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .in      (f2q.consumer),
        .out     (q2x.producer),
        .flush_i (redirect)  // taken branch or jump drops everything fetched
    );

    exec_unit u_exec (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .in                 (q2x.consumer),
        .redirect_o         (redirect),
        .redirect_pc_o      (redirect_pc),
        .rf_raddr_a_o       (rf_raddr_a),
        .rf_raddr_b_o       (rf_raddr_b),
        .rf_rdata_a_i       (rf_rdata_a),
        .rf_rdata_b_i       (rf_rdata_b),
        .rf_we_o            (rf_we),
        .rf_waddr_o         (rf_waddr),
        .rf_wdata_o         (rf_wdata),
        .data_sram_en_o     (data_sram_en_o),
        .data_sram_wen_o    (data_sram_wen_o),
        .data_sram_addr_o   (data_sram_addr_o),
        .data_sram_wdata_o  (data_sram_wdata_o),
        .data_sram_rdata_i  (data_sram_rdata_i),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    reg_file u_rf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_a_i(rf_raddr_a),
        .raddr_b_i(rf_raddr_b),
        .rdata_a_o(rf_rdata_a),
        .rdata_b_o(rf_rdata_b),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

endmodule

// File: testbench/tb_program.svh
// test program, initial data words and expected retirement events, included by the core testbench
localparam logic [31:0] prog_base = 32'hbfc0_0000;  // boot address of the core

typedef struct packed {
    logic [2:0]  grp;
    logic        is_store;
    logic [31:0] addr;      // writeback pc or store address
    logic [4:0]  wnum;
    logic [31:0] data;
} exp_t;

logic [31:0] prog_q [$];
logic [31:0] dmem [logic [31:0]];
exp_t        exp_q [$];

function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] j_word(input logic [31:0] dest);
    return {6'h02, dest[27:2]};  // region bits come from the jump's own pc
endfunction

function automatic logic [31:0] pc_of(input int idx);
    return prog_base + 32'(idx) * 32'd4;
endfunction

// expectation for the instruction pushed last
task automatic expect_wb(input int grp, input logic [4:0] wnum, input logic [31:0] data);
    exp_q.push_back({3'(grp), 1'b0, pc_of(prog_q.size() - 1), wnum, data});
endtask

task automatic expect_store(input int grp, input logic [31:0] addr, input logic [31:0] data);
    exp_q.push_back({3'(grp), 1'b1, addr, 5'd0, data});
endtask

task automatic build_program;
    dmem[32'h0000_0104] = 32'ha5a5_0001;
    dmem[32'h0000_0108] = 32'h1357_9bdf;
    dmem[32'h0000_010c] = 32'h2468_ace0;
    prog_q.push_back(i_word(6'h0f, 5'd1, 5'd0, 16'h1234));       // lui r1
    expect_wb(0, 5'd1, 32'h1234_0000);
    prog_q.push_back(i_word(6'h0d, 5'd1, 5'd1, 16'h8765));       // ori, top bit of imm set
    expect_wb(0, 5'd1, 32'h1234_8765);
    prog_q.push_back(i_word(6'h09, 5'd2, 5'd0, 16'hfff9));       // addiu -7
    expect_wb(0, 5'd2, 32'hffff_fff9);
    prog_q.push_back(i_word(6'h09, 5'd3, 5'd0, 16'h0064));
    expect_wb(0, 5'd3, 32'h0000_0064);
    prog_q.push_back(i_word(6'h09, 5'd0, 5'd0, 16'h0055));       // r0 target, no writeback
    prog_q.push_back(i_word(6'h0d, 5'd4, 5'd0, 16'hf0f0));
    expect_wb(0, 5'd4, 32'h0000_f0f0);
    prog_q.push_back(r_word(6'h21, 5'd5, 5'd1, 5'd3));           // addu
    expect_wb(1, 5'd5, 32'h1234_8765 + 32'h64);
    prog_q.push_back(r_word(6'h23, 5'd6, 5'd3, 5'd2));           // subu
    expect_wb(1, 5'd6, 32'h64 - 32'hffff_fff9);
    prog_q.push_back(r_word(6'h24, 5'd7, 5'd1, 5'd4));           // and
    expect_wb(1, 5'd7, 32'h1234_8765 & 32'hf0f0);
    prog_q.push_back(r_word(6'h25, 5'd8, 5'd3, 5'd4));           // or
    expect_wb(1, 5'd8, 32'h64 | 32'hf0f0);
    prog_q.push_back(r_word(6'h26, 5'd9, 5'd1, 5'd4));           // xor
    expect_wb(1, 5'd9, 32'h1234_8765 ^ 32'hf0f0);
    prog_q.push_back(r_word(6'h2a, 5'd11, 5'd2, 5'd3));          // slt -7 < 100
    expect_wb(1, 5'd11, 32'd1);
    prog_q.push_back(r_word(6'h2a, 5'd12, 5'd3, 5'd2));
    expect_wb(1, 5'd12, 32'd0);
    prog_q.push_back(i_word(6'h09, 5'd10, 5'd0, 16'h0100));      // data base
    expect_wb(2, 5'd10, 32'h0000_0100);
    prog_q.push_back(i_word(6'h2b, 5'd9, 5'd10, 16'h0000));      // sw r9
    expect_store(2, 32'h0000_0100, 32'h1234_8765 ^ 32'hf0f0);
    prog_q.push_back(i_word(6'h23, 5'd13, 5'd10, 16'h0000));     // lw back the stored word
    expect_wb(2, 5'd13, 32'h1234_8765 ^ 32'hf0f0);
    prog_q.push_back(i_word(6'h23, 5'd14, 5'd10, 16'h0004));
    expect_wb(2, 5'd14, 32'ha5a5_0001);
    prog_q.push_back(i_word(6'h23, 5'd15, 5'd10, 16'h0008));
    expect_wb(2, 5'd15, 32'h1357_9bdf);
    prog_q.push_back(i_word(6'h23, 5'd16, 5'd10, 16'h000c));
    expect_wb(2, 5'd16, 32'h2468_ace0);
    prog_q.push_back(r_word(6'h21, 5'd17, 5'd14, 5'd15));
    expect_wb(2, 5'd17, 32'ha5a5_0001 + 32'h1357_9bdf);
    prog_q.push_back(i_word(6'h04, 5'd9, 5'd13, 16'h0002));      // beq taken, skips two
    prog_q.push_back(i_word(6'h09, 5'd20, 5'd0, 16'h0bad));
    prog_q.push_back(i_word(6'h09, 5'd20, 5'd0, 16'h0bae));
    prog_q.push_back(i_word(6'h05, 5'd12, 5'd11, 16'h0001));     // bne taken
    prog_q.push_back(i_word(6'h09, 5'd21, 5'd0, 16'h0baf));
    prog_q.push_back(i_word(6'h04, 5'd12, 5'd11, 16'h0001));     // beq not taken
    prog_q.push_back(i_word(6'h09, 5'd22, 5'd0, 16'h0022));
    expect_wb(3, 5'd22, 32'h0000_0022);
    prog_q.push_back(i_word(6'h05, 5'd3, 5'd3, 16'h0001));       // bne not taken
    prog_q.push_back(i_word(6'h09, 5'd23, 5'd0, 16'h0023));
    expect_wb(3, 5'd23, 32'h0000_0023);
    prog_q.push_back(j_word(pc_of(32)));
    prog_q.push_back(i_word(6'h09, 5'd24, 5'd0, 16'h0bb0));
    prog_q.push_back(i_word(6'h09, 5'd24, 5'd0, 16'h0bb1));
    prog_q.push_back(i_word(6'h09, 5'd25, 5'd0, 16'h0025));
    expect_wb(4, 5'd25, 32'h0000_0025);
    prog_q.push_back(i_word(6'h2b, 5'd25, 5'd10, 16'h0010));
    expect_store(4, 32'h0000_0110, 32'h0000_0025);
    prog_q.push_back(j_word(pc_of(34)));                         // spin here at the end
endtask

// File: testbench/tb_mini_cpu.sv
// core testbench that runs the test program from behavioral srams and checks retirements in order
module tb_mini_cpu;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 8;
    localparam int drain_cycles = 12;  // quiet time after the last expected event

    `include "tb_program.svh"

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic        ireq_q;      // read accepted last cycle
    logic [31:0] iaddr_q;
    logic        dreq_q;
    logic [31:0] daddr_q;
    int          errors = 0;
    int          checks = 0;
    int          grp_errors = 0;
    int          idx = 0;
    bit          table_ready = 1'b0;
    string       grp_name [5];

    mini_cpu_top #(
        .QUEUE_DEPTH(4)
    ) u_dut (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .inst_sram_en_o     (inst_sram_en),
        .inst_sram_addr_o   (inst_sram_addr),
        .inst_sram_rdata_i  (inst_rdata),
        .data_sram_en_o     (data_sram_en),
        .data_sram_wen_o    (data_sram_wen),
        .data_sram_addr_o   (data_sram_addr),
        .data_sram_wdata_o  (data_sram_wdata),
        .data_sram_rdata_i  (data_rdata),
        .debug_wb_pc_o      (debug_wb_pc),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] inst_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = (addr - prog_base) >> 2;
        if (offs < prog_q.size()) begin
            return prog_q[offs];
        end
        return 32'h0000_0000;  // plain nop outside the program
    endfunction

    function automatic logic [31:0] data_word(input logic [31:0] addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return addr ^ 32'h5a5a_c3c3;  // untouched words follow their address
    endfunction

    // both srams answer one cycle after the request
    always @(negedge clk) begin
        if (ireq_q) begin
            inst_rdata = inst_word(iaddr_q);
        end
        ireq_q  = inst_sram_en;
        iaddr_q = inst_sram_addr;
        if (dreq_q) begin
            data_rdata = data_word(daddr_q);
        end
        dreq_q  = data_sram_en && (data_sram_wen == 4'h0);
        daddr_q = data_sram_addr;
        if (data_sram_en && (data_sram_wen == 4'hf)) begin
            dmem[data_sram_addr] = data_sram_wdata;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            grp_errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic match_event(input bit is_store, input logic [31:0] addr,
                               input logic [4:0] wnum, input logic [31:0] data);
        exp_t e;
        if (idx >= exp_q.size()) begin
            errors++;
            $display("unexpected %s at t=%0t after the program should have ended",
                     is_store ? "store" : "writeback", $time);
            return;
        end
        e = exp_q[idx];
        check("event kind (1 = store)", 32'(e.is_store), 32'(is_store));
        if (e.is_store) begin
            check("data_sram_addr_o", e.addr, addr);
            check("data_sram_wdata_o", e.data, data);
        end else begin
            check("debug_wb_pc_o", e.addr, addr);
            check("debug_wb_rf_wnum_o", 32'(e.wnum), 32'(wnum));
            check("debug_wb_rf_wdata_o", e.data, data);
        end
        idx++;
        if (idx == exp_q.size() || exp_q[idx].grp != e.grp) begin
            $display("test %-9s finished, %0d mismatches", grp_name[e.grp], grp_errors);
            grp_errors = 0;
        end
    endtask

    // a writeback and a store can share a cycle and the writeback is older
    task automatic collect_events;
        if (debug_wb_rf_wen != 4'h0) begin
            check("debug_wb_rf_wen_o", 32'h0000_000f, 32'(debug_wb_rf_wen));  // full word write
            match_event(1'b0, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
        end
        if (data_sram_en && (data_sram_wen == 4'hf)) begin
            match_event(1'b1, data_sram_addr, 5'd0, data_sram_wdata);
        end
    endtask

    initial begin : watchdog
        wait (table_ready);
        #((reset_cycles + 20 * exp_q.size()) * clk_period);
        $display("timeout: the program did not finish, %0d of %0d events seen",
                 idx, exp_q.size());
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        arst_n_i   = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        ireq_q     = 1'b0;
        iaddr_q    = '0;
        dreq_q     = 1'b0;
        daddr_q    = '0;
        grp_name   = '{"constants", "alu", "memory", "branch", "jump"};
        build_program();
        table_ready = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        check("inst_sram_en_o", 32'd0, 32'(inst_sram_en));
        check("data_sram_en_o", 32'd0, 32'(data_sram_en));
        check("data_sram_wen_o", 32'd0, 32'(data_sram_wen));
        check("debug_wb_rf_wen_o", 32'd0, 32'(debug_wb_rf_wen));
        $display("test %-9s finished, %0d mismatches", "reset", grp_errors);
        grp_errors = 0;
        arst_n_i   = 1'b1;
        while (idx < exp_q.size()) begin
            @(negedge clk);
            collect_events();
        end
        repeat (drain_cycles) begin
            @(negedge clk);
            collect_events();
        end
        $display("checks %0d, errors %0d, events %0d of %0d", checks, errors, idx, exp_q.size());
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+testbench
common/cpu_pkg.sv
common/instr_if.sv
fetch/fetch_unit.sv
fetch/fetch_queue.sv
execute/exec_unit.sv
logic/reg_file.sv
logic/mini_cpu_top.sv
testbench/tb_mini_cpu.sv
